// File: Bender.yml
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - mem_ctrl_regs.sv
  - fetch_cache.sv
  - data_cache.sv
  - mem_arbiter.sv
  - backing_ram.sv
  - mem_subsys_top.sv
  - target: simulation
    files:
      - mem_subsys_assert.sv
      - mem_subsys_tb.sv

// File: backing_ram.sv
module backing_ram
(
        input  logic                            i_clk,
        input  logic                            i_ram_en,
        input  logic                            i_ram_we,
        input  logic [mem_pkg::WADDR_W-1:0]     i_ram_addr,
        input  logic [mem_pkg::DATA_W-1:0]      i_ram_wdata,
        input  logic [mem_pkg::DATA_W/8-1:0]    i_ram_ben,
        output logic [mem_pkg::DATA_W-1:0]      o_ram_rdata
);

logic [mem_pkg::DATA_W-1:0] mem [mem_pkg::RAM_WORDS];

initial
begin
        for (int i = 0; i < mem_pkg::RAM_WORDS; i++)
                mem[i] = '0;
end

always_ff @(posedge i_clk)
begin
        if (i_ram_en)
        begin
                if (i_ram_we)
                begin
                        for (int b = 0; b < mem_pkg::DATA_W / 8; b++)
                                if (i_ram_ben[b])
                                        mem[i_ram_addr][8*b +: 8] <= i_ram_wdata[8*b +: 8];
                end
                else
                        o_ram_rdata <= mem[i_ram_addr];         // Registered read.
        end
end

endmodule

// File: data_cache.sv
module data_cache
(
        input  logic                  i_clk,
        input  logic                  i_rst_n,
        input  logic                  i_req_valid,
        input  mem_pkg::cpu_req_t     i_req,
        output logic                  o_ready,
        output mem_pkg::cpu_rsp_t     o_rsp,
        input  mem_pkg::cache_ctrl_t  i_ctrl,
        output logic                  o_mem_valid,
        output mem_pkg::mem_req_t     o_mem_req,
        input  logic                  i_credit,
        input  mem_pkg::mem_rsp_t     i_mem_rsp
);

typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT} state_e;

state_e                       state_q;
mem_pkg::mem_req_t            req_q;
logic [mem_pkg::TAG_W-1:0]    tag_q  [mem_pkg::LINES];
logic [mem_pkg::DATA_W-1:0]   data_q [mem_pkg::LINES];
logic [mem_pkg::LINES-1:0]    valid_q;
logic [mem_pkg::CRED_W-1:0]   credit_q;
logic [mem_pkg::IDX_W-1:0]    idx, req_idx;
logic [mem_pkg::TAG_W-1:0]    tag, req_tag;
logic                         accept, abort, tag_match, hit, fill;

assign idx     = i_req.addr[mem_pkg::IDX_W+1:2];
assign tag     = i_req.addr[mem_pkg::WADDR_W+1:mem_pkg::IDX_W+2];
assign req_idx = req_q.addr[mem_pkg::IDX_W-1:0];
assign req_tag = req_q.addr[mem_pkg::WADDR_W-1:mem_pkg::IDX_W];

assign o_ready   = (state_q == S_IDLE);
assign accept    = i_req_valid && o_ready;
assign abort     = mem_pkg::is_protected(i_req.mode, i_req.addr, i_ctrl);
assign tag_match = valid_q[idx] && (tag_q[idx] == tag);
assign hit       = i_ctrl.en && tag_match;      // Read hits only when enabled.
assign fill      = (state_q == S_WAIT) && i_mem_rsp.valid && i_ctrl.en;

assign o_mem_valid = (state_q == S_SEND) && (credit_q != '0);
assign o_mem_req   = req_q;

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
                credit_q <= mem_pkg::CRED_W'(mem_pkg::CREDITS);
        else
                credit_q <= credit_q - o_mem_valid + i_credit;
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                state_q <= S_IDLE;
                o_rsp   <= '0;
        end
        else
        begin
                o_rsp.valid <= 1'b0;
                o_rsp.abort <= 1'b0;
                case (state_q)
                S_IDLE:
                        if (accept)
                        begin
                                if (abort)
                                begin
                                        o_rsp.valid <= 1'b1;
                                        o_rsp.abort <= 1'b1;
                                end
                                else if (i_req.op == mem_pkg::OP_READ && hit)
                                begin
                                        o_rsp.valid <= 1'b1;
                                        o_rsp.data  <= data_q[idx];
                                end
                                else
                                        state_q <= S_SEND;
                        end
                S_SEND:
                        if (o_mem_valid)
                        begin
                                if (req_q.op == mem_pkg::OP_WRITE)
                                begin
                                        o_rsp.valid <= 1'b1;    // Posted write.
                                        o_rsp.data  <= '0;
                                        state_q     <= S_IDLE;
                                end
                                else
                                        state_q <= S_WAIT;
                        end
                S_WAIT:
                        if (i_mem_rsp.valid)
                        begin
                                o_rsp.valid <= 1'b1;
                                o_rsp.data  <= i_mem_rsp.data;
                                state_q     <= S_IDLE;
                        end
                default: state_q <= S_IDLE;
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                req_q.op    <= i_req.op;
                req_q.addr  <= i_req.addr[mem_pkg::WADDR_W+1:2];
                req_q.wdata <= i_req.wdata;
                req_q.ben   <= i_req.ben;
        end
        // Keep a resident line current even while caching is off.
        if (accept && !abort && i_req.op == mem_pkg::OP_WRITE && tag_match)
        begin
                for (int b = 0; b < mem_pkg::DATA_W / 8; b++)
                        if (i_req.ben[b])
                                data_q[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
        if (fill)
        begin
                tag_q[req_idx]  <= req_tag;
                data_q[req_idx] <= i_mem_rsp.data;
        end
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n || i_ctrl.flush)
                valid_q <= '0;
        else if (fill)
                valid_q[req_idx] <= 1'b1;
end

endmodule

// File: fetch_cache.sv
module fetch_cache
(
        input  logic                  i_clk,
        input  logic                  i_rst_n,
        input  logic                  i_req_valid,
        input  mem_pkg::cpu_req_t     i_req,
        output logic                  o_ready,
        output mem_pkg::cpu_rsp_t     o_rsp,
        input  mem_pkg::cache_ctrl_t  i_ctrl,
        output logic                  o_mem_valid,
        output mem_pkg::mem_req_t     o_mem_req,
        input  logic                  i_credit,
        input  mem_pkg::mem_rsp_t     i_mem_rsp
);

typedef enum logic {S_IDLE, S_REFILL} state_e;

state_e                       state_q;
logic [mem_pkg::TAG_W-1:0]    tag_q  [mem_pkg::LINES];
logic [mem_pkg::DATA_W-1:0]   data_q [mem_pkg::LINES];
logic [mem_pkg::LINES-1:0]    valid_q;
logic [mem_pkg::CRED_W-1:0]   credit_q;
logic [mem_pkg::IDX_W-1:0]    idx, fill_idx_q;
logic [mem_pkg::TAG_W-1:0]    tag, fill_tag_q;
logic                         accept, abort, hit, fill;

assign idx = i_req.addr[mem_pkg::IDX_W+1:2];
assign tag = i_req.addr[mem_pkg::WADDR_W+1:mem_pkg::IDX_W+2];

// Hold off new fetches while a refill is out or no credit is left.
assign o_ready     = (state_q == S_IDLE) && (credit_q != '0);
assign accept      = i_req_valid && o_ready;
assign abort       = mem_pkg::is_protected(i_req.mode, i_req.addr, i_ctrl);
assign hit         = i_ctrl.en && valid_q[idx] && (tag_q[idx] == tag);
assign o_mem_valid = accept && !abort && !hit;  // Refill read goes out at once.
assign fill        = (state_q == S_REFILL) && i_mem_rsp.valid && i_ctrl.en;

always_comb
begin
        o_mem_req       = '0;
        o_mem_req.op    = mem_pkg::OP_READ;
        o_mem_req.addr  = i_req.addr[mem_pkg::WADDR_W+1:2];
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
                credit_q <= mem_pkg::CRED_W'(mem_pkg::CREDITS);
        else
                credit_q <= credit_q - o_mem_valid + i_credit;
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                state_q <= S_IDLE;
                o_rsp   <= '0;
        end
        else
        begin
                o_rsp.valid <= 1'b0;
                o_rsp.abort <= 1'b0;
                case (state_q)
                S_IDLE:
                        if (accept)
                        begin
                                if (abort)
                                begin
                                        o_rsp.valid <= 1'b1;
                                        o_rsp.abort <= 1'b1;
                                end
                                else if (hit)
                                begin
                                        o_rsp.valid <= 1'b1;
                                        o_rsp.data  <= data_q[idx];
                                end
                                else
                                        state_q <= S_REFILL;
                        end
                S_REFILL:
                        if (i_mem_rsp.valid)
                        begin
                                o_rsp.valid <= 1'b1;
                                o_rsp.data  <= i_mem_rsp.data;
                                state_q     <= S_IDLE;
                        end
                default: state_q <= S_IDLE;
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                fill_idx_q <= idx;
                fill_tag_q <= tag;
        end
        if (fill)
        begin
                tag_q[fill_idx_q]  <= fill_tag_q;
                data_q[fill_idx_q] <= i_mem_rsp.data;
        end
end

// Flush beats a fill on the same edge.
always_ff @(posedge i_clk)
begin
        if (!i_rst_n || i_ctrl.flush)
                valid_q <= '0;
        else if (fill)
                valid_q[fill_idx_q] <= 1'b1;
end

endmodule

// File: list.f
mem_pkg.sv
mem_ctrl_regs.sv
fetch_cache.sv
data_cache.sv
mem_arbiter.sv
backing_ram.sv
mem_subsys_top.sv
mem_subsys_assert.sv
mem_subsys_tb.sv

// File: mem_arbiter.sv
module mem_arbiter
(
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic                            i_f_valid,
        input  mem_pkg::mem_req_t               i_f_req,
        output logic                            o_f_credit,
        output mem_pkg::mem_rsp_t               o_f_rsp,
        input  logic                            i_d_valid,
        input  mem_pkg::mem_req_t               i_d_req,
        output logic                            o_d_credit,
        output mem_pkg::mem_rsp_t               o_d_rsp,
        output logic                            o_ram_en,
        output logic                            o_ram_we,
        output logic [mem_pkg::WADDR_W-1:0]     o_ram_addr,
        output logic [mem_pkg::DATA_W-1:0]      o_ram_wdata,
        output logic [mem_pkg::DATA_W/8-1:0]    o_ram_ben,
        input  logic [mem_pkg::DATA_W-1:0]      i_ram_rdata
);

// Port 0 is fetch, port 1 is data.
mem_pkg::mem_req_t              queue_q  [2][mem_pkg::CREDITS];
mem_pkg::mem_req_t              push_req [2];
logic [mem_pkg::QPTR_W-1:0]     wr_ptr_q [2];
logic [mem_pkg::QPTR_W-1:0]     rd_ptr_q [2];
logic [mem_pkg::CRED_W-1:0]     count_q  [2];
logic [1:0]                     push, pop;
mem_pkg::mem_req_t              head;
logic                           rd_pend_q, rd_port_q;

assign push        = {i_d_valid, i_f_valid};
assign push_req[0] = i_f_req;
assign push_req[1] = i_d_req;

// Data first, so posted writes stay ahead of later refills.
assign pop[1] = (count_q[1] != '0);
assign pop[0] = (count_q[0] != '0) && !pop[1];
assign head   = pop[1] ? queue_q[1][rd_ptr_q[1]] : queue_q[0][rd_ptr_q[0]];

assign o_ram_en    = |pop;
assign o_ram_we    = o_ram_en && (head.op == mem_pkg::OP_WRITE);
assign o_ram_addr  = head.addr;
assign o_ram_wdata = head.wdata;
assign o_ram_ben   = head.ben;

assign o_f_credit = pop[0];                     // One credit per pop.
assign o_d_credit = pop[1];

always_comb
begin
        o_f_rsp.valid = rd_pend_q && !rd_port_q;
        o_f_rsp.data  = i_ram_rdata;
        o_d_rsp.valid = rd_pend_q && rd_port_q;
        o_d_rsp.data  = i_ram_rdata;
end

always_ff @(posedge i_clk)
begin
        for (int p = 0; p < 2; p++)
                if (push[p])
                        queue_q[p][wr_ptr_q[p]] <= push_req[p];
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                for (int p = 0; p < 2; p++)
                begin
                        wr_ptr_q[p] <= '0;
                        rd_ptr_q[p] <= '0;
                        count_q[p]  <= '0;
                end
                rd_pend_q <= 1'b0;
        end
        else
        begin
                for (int p = 0; p < 2; p++)
                begin
                        if (push[p])
                                wr_ptr_q[p] <= wr_ptr_q[p] + 1'b1;
                        if (pop[p])
                                rd_ptr_q[p] <= rd_ptr_q[p] + 1'b1;
                        count_q[p] <= count_q[p] + push[p] - pop[p];
                end
                rd_pend_q <= o_ram_en && !o_ram_we;     // Read data next cycle.
        end
        rd_port_q <= pop[1];
end

endmodule

// File: mem_ctrl_regs.sv
module mem_ctrl_regs
(
        input  logic                         i_clk,
        input  logic                         i_rst_n,
        input  logic                         i_cfg_we,
        input  mem_pkg::cfg_sel_e            i_cfg_sel,
        input  logic [mem_pkg::DATA_W-1:0]   i_cfg_wdata,
        output mem_pkg::cache_ctrl_t         o_ctrl
);

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_ctrl <= '0;                   // Disabled, empty window.
        end
        else
        begin
                o_ctrl.flush <= 1'b0;           // Self clearing.
                if (i_cfg_we)
                begin
                        case (i_cfg_sel)
                        mem_pkg::CFG_CTRL:
                        begin
                                o_ctrl.en    <= i_cfg_wdata[0];
                                o_ctrl.flush <= i_cfg_wdata[1];
                        end
                        mem_pkg::CFG_PROT_BASE:  o_ctrl.prot_base  <= i_cfg_wdata;
                        mem_pkg::CFG_PROT_LIMIT: o_ctrl.prot_limit <= i_cfg_wdata;
                        default: ;
                        endcase
                end
        end
end

endmodule

// File: mem_pkg.sv
package mem_pkg;

        localparam int ADDR_W    = 32;
        localparam int DATA_W    = 32;
        localparam int LINES     = 64;
        localparam int RAM_WORDS = 1024;
        localparam int CREDITS   = 2;

        localparam int WADDR_W = $clog2(RAM_WORDS);     // Word address into RAM.
        localparam int IDX_W   = $clog2(LINES);         // Cache index, addr[7:2].
        localparam int TAG_W   = WADDR_W - IDX_W;       // Cache tag, addr[11:8].
        localparam int CRED_W  = $clog2(CREDITS + 1);
        localparam int QPTR_W  = $clog2(CREDITS);

        localparam logic [4:0] MODE_USR = 5'b10000;

        typedef enum logic [1:0] {
                CFG_CTRL,
                CFG_PROT_BASE,
                CFG_PROT_LIMIT
        } cfg_sel_e;

        typedef enum logic {
                OP_READ,
                OP_WRITE
        } mem_op_e;

        typedef struct packed {
                logic              en;
                logic              flush;
                logic [ADDR_W-1:0] prot_base;
                logic [ADDR_W-1:0] prot_limit;
        } cache_ctrl_t;

        typedef struct packed {
                mem_op_e             op;
                logic [WADDR_W-1:0]  addr;
                logic [DATA_W-1:0]   wdata;
                logic [DATA_W/8-1:0] ben;
        } mem_req_t;

        typedef struct packed {
                logic              valid;
                logic [DATA_W-1:0] data;
        } mem_rsp_t;

        typedef struct packed {
                logic [ADDR_W-1:0]   addr;
                logic [DATA_W-1:0]   wdata;
                logic [DATA_W/8-1:0] ben;
                mem_op_e             op;
                logic [4:0]          mode;      // CPSR mode field.
        } cpu_req_t;

        typedef struct packed {
                logic              valid;
                logic              abort;
                logic [DATA_W-1:0] data;
        } cpu_rsp_t;

        // User mode inside [base, limit) is refused.
        function automatic logic is_protected(input logic [4:0] mode,
                                              input logic [ADDR_W-1:0] addr,
                                              input cache_ctrl_t ctrl);
                return (mode == MODE_USR) && (ctrl.prot_base <= addr) &&
                       (addr < ctrl.prot_limit);
        endfunction

endpackage

// File: mem_subsys_assert.sv
module mem_subsys_assert
(
        input  logic                    i_clk,
        input  logic                    i_rst_n,
        input  logic                    i_f_mem_valid,
        input  logic                    i_f_credit,
        input  logic                    i_d_mem_valid,
        input  logic                    i_d_credit,
        input  mem_pkg::cpu_rsp_t       i_fetch_rsp,
        input  mem_pkg::cpu_rsp_t       i_data_rsp
);

logic [3:0] f_count, d_count;           // Credits seen on the cache side.

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                f_count <= 4'(mem_pkg::CREDITS);
                d_count <= 4'(mem_pkg::CREDITS);
        end
        else
        begin
                f_count <= f_count - i_f_mem_valid + i_f_credit;
                d_count <= d_count - i_d_mem_valid + i_d_credit;
        end
end

fetch_credit_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        f_count <= mem_pkg::CREDITS) else $error("Fetch credit count above its limit.");
data_credit_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        d_count <= mem_pkg::CREDITS) else $error("Data credit count above its limit.");
fetch_send_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_f_mem_valid |-> f_count != 0) else $error("Fetch request sent with no credit.");
data_send_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_d_mem_valid |-> d_count != 0) else $error("Data request sent with no credit.");
fetch_abort_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fetch_rsp.abort |-> i_fetch_rsp.valid) else $error("Fetch abort without valid.");
data_abort_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_data_rsp.abort |-> i_data_rsp.valid) else $error("Data abort without valid.");

endmodule

bind mem_subsys_top mem_subsys_assert mem_subsys_assert_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_f_mem_valid(f_mem_valid),
        .i_f_credit(f_credit),
        .i_d_mem_valid(d_mem_valid),
        .i_d_credit(d_credit),
        .i_fetch_rsp(o_fetch_rsp),
        .i_data_rsp(o_data_rsp)
);

// File: mem_subsys_tb.sv
module mem_subsys_tb;

localparam int CLK_PERIOD = 40;
localparam int N_BYTE     = 16;
localparam int N_RAND     = 60;
localparam int N_CONC     = 40;
localparam int N_ACCESS   = 3 * N_BYTE + N_RAND + 2 * N_CONC + 20;
localparam logic [4:0] MODE_SVC = 5'b10011;

typedef struct packed {
        logic [63:0] t_acc;             // Acceptance edge.
        logic        one_cycle;
        logic        abort;
        logic        check_data;
        logic [31:0] data;
} exp_t;

logic                   i_clk, i_rst_n, i_cfg_we;
mem_pkg::cfg_sel_e      i_cfg_sel;
logic [31:0]            i_cfg_wdata;
logic                   i_fetch_req_valid, i_data_req_valid, o_fetch_ready, o_data_ready;
mem_pkg::cpu_req_t      i_fetch_req, i_data_req;
mem_pkg::cpu_rsp_t      o_fetch_rsp, o_data_rsp;

logic [31:0]            ram_model [mem_pkg::RAM_WORDS];
logic [31:0]            prot_base, prot_limit, rng, rng_f, old_word, r;
logic [31:0]            addr_list [N_BYTE];
exp_t                   fetch_exp_q [$];
exp_t                   data_exp_q [$];

mem_subsys_top mem_subsys_top_inst (.*);

initial
        i_clk = 1'b0;
always #(CLK_PERIOD / 2) i_clk = ~i_clk;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
endfunction

function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
endfunction

// Expected response from the memory model; writes land in the model.
function automatic exp_t reference_access(input mem_pkg::cpu_req_t req);
        exp_t       e;
        logic [9:0] w;
        e       = '0;
        w       = req.addr[11:2];       // 4 KB RAM, upper bits dropped.
        e.abort = (req.mode == mem_pkg::MODE_USR) && (prot_base <= req.addr) &&
                  (req.addr < prot_limit);
        if (!e.abort && req.op == mem_pkg::OP_WRITE)
                for (int b = 0; b < 4; b++)
                        if (req.ben[b])
                                ram_model[w][8*b +: 8] = req.wdata[8*b +: 8];
        e.check_data = !e.abort && (req.op == mem_pkg::OP_READ);
        e.data       = ram_model[w];
        return e;
endfunction

task automatic report_and_stop(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped.");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
                report_and_stop("Response value mismatch.");
        end
endtask

task automatic check_response(input string port, input mem_pkg::cpu_rsp_t rsp, input exp_t e);
        // Seen half a cycle after the edge that registered it.
        if (e.one_cycle)
                check_value({port, ".latency"}, 32'($time - e.t_acc), 32'(CLK_PERIOD / 2));
        check_value({port, ".abort"}, 32'(rsp.abort), 32'(e.abort));
        if (e.check_data)
                check_value({port, ".data"}, rsp.data, e.data);
endtask

// Responses are stable at the falling edge.
always @(negedge i_clk)
begin
        if (o_data_rsp.valid)
        begin
                if (data_exp_q.size() == 0)
                        report_and_stop("Data port responded with no access outstanding.");
                else
                        check_response("o_data_rsp", o_data_rsp, data_exp_q.pop_front());
        end
        if (o_fetch_rsp.valid)
        begin
                if (fetch_exp_q.size() == 0)
                        report_and_stop("Fetch port responded with no access outstanding.");
                else
                        check_response("o_fetch_rsp", o_fetch_rsp, fetch_exp_q.pop_front());
        end
end

initial
begin
        repeat (16 + 200 * N_ACCESS) @(posedge i_clk);
        report_and_stop("Watchdog timeout: the accesses did not complete in time.");
end

task automatic access(input logic is_data, input mem_pkg::cpu_req_t req, input logic expect_hit,
                      input logic use_old, input logic [31:0] old_data);
        exp_t e;
        @(negedge i_clk);
        if (is_data)
        begin
                i_data_req_valid = 1'b1;
                i_data_req       = req;
                while (!o_data_ready)
                        @(negedge i_clk);
        end
        else
        begin
                i_fetch_req_valid = 1'b1;
                i_fetch_req       = req;
                while (!o_fetch_ready)
                        @(negedge i_clk);
        end
        @(posedge i_clk);                       // Accepted here.
        e           = reference_access(req);
        e.t_acc     = $time;
        e.one_cycle = e.abort || expect_hit;
        if (use_old)
                e.data = old_data;              // Stale line, no coherence.
        if (is_data)
                data_exp_q.push_back(e);
        else
                fetch_exp_q.push_back(e);
        @(negedge i_clk);
        if (is_data)
                i_data_req_valid = 1'b0;
        else
                i_fetch_req_valid = 1'b0;
endtask

task automatic data_op(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] ben,
                       input logic [4:0] mode, input logic expect_hit);
        mem_pkg::cpu_req_t req;
        req.addr  = addr;
        req.wdata = wdata;
        req.ben   = ben;
        req.op    = op;
        req.mode  = mode;
        access(1'b1, req, expect_hit, 1'b0, '0);
endtask

task automatic fetch_op(input logic [31:0] addr, input logic [4:0] mode, input logic expect_hit,
                        input logic use_old, input logic [31:0] old_data);
        mem_pkg::cpu_req_t req;
        req      = '0;
        req.addr = addr;
        req.op   = mem_pkg::OP_READ;
        req.mode = mode;
        access(1'b0, req, expect_hit, use_old, old_data);
endtask

task automatic random_data(input logic [31:0] base, input logic [31:0] mask, input logic vary_mode);
        logic [31:0] a, wdata;
        a     = next_rand();
        wdata = next_rand();
        data_op(a[31] ? mem_pkg::OP_WRITE : mem_pkg::OP_READ, base | (a & mask), wdata, a[23:20],
                (vary_mode && a[16]) ? mem_pkg::MODE_USR : MODE_SVC, 1'b0);
endtask

task automatic random_fetch(input logic [31:0] mask);
        rng_f = xorshift32(rng_f);
        fetch_op(rng_f & mask, rng_f[16] ? mem_pkg::MODE_USR : MODE_SVC, 1'b0, 1'b0, '0);
endtask

task automatic drain();
        while (data_exp_q.size() != 0 || fetch_exp_q.size() != 0)
                @(negedge i_clk);
endtask

task automatic write_config(input mem_pkg::cfg_sel_e sel, input logic [31:0] value);
        drain();
        @(negedge i_clk);
        i_cfg_we    = 1'b1;
        i_cfg_sel   = sel;
        i_cfg_wdata = value;
        @(negedge i_clk);
        i_cfg_we = 1'b0;
        if (sel == mem_pkg::CFG_PROT_BASE)
                prot_base = value;
        else if (sel == mem_pkg::CFG_PROT_LIMIT)
                prot_limit = value;
endtask

initial
begin
        i_rst_n           = 1'b0;
        i_cfg_we          = 1'b0;
        i_cfg_sel         = mem_pkg::CFG_CTRL;
        i_cfg_wdata       = '0;
        i_fetch_req_valid = 1'b0;
        i_fetch_req       = '0;
        i_data_req_valid  = 1'b0;
        i_data_req        = '0;
        rng               = 32'd16;
        prot_base         = '0;
        prot_limit        = '0;
        for (int i = 0; i < mem_pkg::RAM_WORDS; i++)
                ram_model[i] = '0;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;

        // Caching is off after reset, so every access goes to RAM.
        for (int i = 0; i < N_BYTE; i++)
                addr_list[i] = next_rand() & 32'h0000_0FFC;
        for (int pass = 0; pass < 2; pass++)
                for (int i = 0; i < N_BYTE; i++)
                begin
                        r = next_rand();
                        data_op(mem_pkg::OP_WRITE, addr_list[i], r, (pass == 0) ? 4'hF : r[31:28],
                                MODE_SVC, 1'b0);
                end
        for (int i = 0; i < N_BYTE; i++)
                data_op(mem_pkg::OP_READ, addr_list[i], '0, '0, MODE_SVC, 1'b0);

        write_config(mem_pkg::CFG_CTRL, 32'h1);
        for (int i = 0; i < N_RAND; i++)
                random_data(32'h0, 32'h1FC, 1'b0);      // Two tags per index.
        data_op(mem_pkg::OP_READ, 32'h0A0, '0, '0, MODE_SVC, 1'b0);
        drain();
        data_op(mem_pkg::OP_READ, 32'h0A0, '0, '0, MODE_SVC, 1'b1);

        write_config(mem_pkg::CFG_CTRL, 32'h3);
        fetch_op(32'h040, MODE_SVC, 1'b0, 1'b0, '0);
        drain();
        fetch_op(32'h040, MODE_SVC, 1'b1, 1'b0, '0);
        old_word = ram_model[32'h040 >> 2];
        data_op(mem_pkg::OP_WRITE, 32'h040, ~old_word, 4'hF, MODE_SVC, 1'b0);
        drain();
        fetch_op(32'h040, MODE_SVC, 1'b1, 1'b1, old_word);
        write_config(mem_pkg::CFG_CTRL, 32'h3);
        fetch_op(32'h040, MODE_SVC, 1'b0, 1'b0, '0);

        write_config(mem_pkg::CFG_PROT_BASE, 32'h100);
        write_config(mem_pkg::CFG_PROT_LIMIT, 32'h200);
        data_op(mem_pkg::OP_WRITE, 32'h140, 32'hDEAD_BEEF, 4'hF, mem_pkg::MODE_USR, 1'b0);
        data_op(mem_pkg::OP_READ, 32'h140, '0, '0, MODE_SVC, 1'b0);
        data_op(mem_pkg::OP_READ, 32'h1FC, '0, '0, mem_pkg::MODE_USR, 1'b0);
        data_op(mem_pkg::OP_READ, 32'h200, '0, '0, mem_pkg::MODE_USR, 1'b0);   // Limit excluded.
        data_op(mem_pkg::OP_WRITE, 32'h0FC, 32'h1234_5678, 4'hF, mem_pkg::MODE_USR, 1'b0);
        data_op(mem_pkg::OP_WRITE, 32'h150, 32'hCAFE_F00D, 4'h3, MODE_SVC, 1'b0);
        data_op(mem_pkg::OP_READ, 32'h150, '0, '0, MODE_SVC, 1'b0);
        fetch_op(32'h110, mem_pkg::MODE_USR, 1'b0, 1'b0, '0);
        fetch_op(32'h110, MODE_SVC, 1'b0, 1'b0, '0);
        fetch_op(32'h300, mem_pkg::MODE_USR, 1'b0, 1'b0, '0);

        // Fetch and data regions kept apart while both ports run.
        write_config(mem_pkg::CFG_CTRL, 32'h3);
        rng_f = next_rand();
        fork
                for (int i = 0; i < N_CONC; i++)
                        random_data(32'h800, 32'h1FC, 1'b1);
                for (int j = 0; j < N_CONC; j++)
                        random_fetch(32'h3FC);
        join
        drain();

        $display("STATUS: PASS");
        $finish;
end

endmodule

// File: mem_subsys_top.sv
module mem_subsys_top
(
        input  logic                            i_clk,
        input  logic                            i_rst_n,
        input  logic                            i_cfg_we,
        input  mem_pkg::cfg_sel_e               i_cfg_sel,
        input  logic [mem_pkg::DATA_W-1:0]      i_cfg_wdata,
        input  logic                            i_fetch_req_valid,
        input  mem_pkg::cpu_req_t               i_fetch_req,
        output logic                            o_fetch_ready,
        output mem_pkg::cpu_rsp_t               o_fetch_rsp,
        input  logic                            i_data_req_valid,
        input  mem_pkg::cpu_req_t               i_data_req,
        output logic                            o_data_ready,
        output mem_pkg::cpu_rsp_t               o_data_rsp
);

mem_pkg::cache_ctrl_t                   ctrl;
logic                                   f_mem_valid, d_mem_valid;
mem_pkg::mem_req_t                      f_mem_req, d_mem_req;
logic                                   f_credit, d_credit;
mem_pkg::mem_rsp_t                      f_mem_rsp, d_mem_rsp;
logic                                   ram_en, ram_we;
logic [mem_pkg::WADDR_W-1:0]            ram_addr;
logic [mem_pkg::DATA_W-1:0]             ram_wdata, ram_rdata;
logic [mem_pkg::DATA_W/8-1:0]           ram_ben;

mem_ctrl_regs mem_ctrl_regs_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg_we(i_cfg_we),
        .i_cfg_sel(i_cfg_sel), .i_cfg_wdata(i_cfg_wdata), .o_ctrl(ctrl)
);

fetch_cache fetch_cache_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_req_valid(i_fetch_req_valid), .i_req(i_fetch_req),
        .o_ready(o_fetch_ready), .o_rsp(o_fetch_rsp), .i_ctrl(ctrl),
        .o_mem_valid(f_mem_valid), .o_mem_req(f_mem_req),
        .i_credit(f_credit), .i_mem_rsp(f_mem_rsp)
);

data_cache data_cache_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_req_valid(i_data_req_valid), .i_req(i_data_req),
        .o_ready(o_data_ready), .o_rsp(o_data_rsp), .i_ctrl(ctrl),
        .o_mem_valid(d_mem_valid), .o_mem_req(d_mem_req),
        .i_credit(d_credit), .i_mem_rsp(d_mem_rsp)
);

mem_arbiter mem_arbiter_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_f_valid(f_mem_valid), .i_f_req(f_mem_req),
        .o_f_credit(f_credit), .o_f_rsp(f_mem_rsp),
        .i_d_valid(d_mem_valid), .i_d_req(d_mem_req),
        .o_d_credit(d_credit), .o_d_rsp(d_mem_rsp),
        .o_ram_en(ram_en), .o_ram_we(ram_we), .o_ram_addr(ram_addr),
        .o_ram_wdata(ram_wdata), .o_ram_ben(ram_ben), .i_ram_rdata(ram_rdata)
);

backing_ram backing_ram_inst (
        .i_clk(i_clk), .i_ram_en(ram_en), .i_ram_we(ram_we),
        .i_ram_addr(ram_addr), .i_ram_wdata(ram_wdata),
        .i_ram_ben(ram_ben), .o_ram_rdata(ram_rdata)
);

endmodule
